/* source/comparator_pkg.sv */
package comparator_pkg;

	// bus address: physical core in bits 7:4, register offset in bits 3:0
	typedef logic [7:0] addr_t;
	typedef logic [31:0] data_t;

	typedef logic [15:0] fprint_half_t;
	typedef logic [31:0] fprint_t;

	typedef logic [3:0] task_id_t;
	// one bit per task id
	typedef logic [15:0] task_mask_t;
	typedef logic [3:0] phys_core_t;

	// register offsets within a core's address window
	localparam logic [3:0] off_cs = 4'd0;
	localparam logic [3:0] off_fprint = 4'd1;
	localparam logic [3:0] off_map = 4'd2;

	// checkout when set, checkin when clear
	localparam int cs_dir_bit = 4;
	// 0 selects the low half, 1 the high half
	localparam int block_bit = 5;

endpackage

/* source/write_fifo.sv */
`timescale 1ns/1ps

module write_fifo import comparator_pkg::*; #(
	parameter int fifo_depth_log2 = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic [$bits(addr_t)+$bits(data_t)-1:0] data_in,
	input  logic wr_en,
	input  logic rd_en,
	output logic [$bits(addr_t)+$bits(data_t)-1:0] data_out,
	output logic empty,
	output logic full
);

	localparam int depth = 1 << fifo_depth_log2;

	logic [$bits(addr_t)+$bits(data_t)-1:0] mem [depth];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	logic [fifo_depth_log2:0] count;
	logic do_write;
	logic do_read;

	assign do_write = wr_en && !full;
	assign do_read = rd_en && !empty;
	assign empty = (count == '0);
	assign full = (count == depth[fifo_depth_log2:0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the fill level unchanged
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr];
	end

endmodule

/* source/core_id_map.sv */
`timescale 1ns/1ps

module core_id_map import comparator_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic map_write,
	input  phys_core_t map_core,
	input  logic map_logical,
	input  phys_core_t physical_core_id,
	output logic logical_core_id
);

	// one logical core bit per physical core
	logic [2**$bits(phys_core_t)-1:0] map_table;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// even physical cores start as logical 0, odd ones as logical 1
			map_table <= 16'haaaa;
		end else if (map_write) begin
			map_table[map_core] <= map_logical;
		end
	end

	assign logical_core_id = map_table[physical_core_id];

endmodule

/* source/fprint_registers.sv */
`timescale 1ns/1ps

module fprint_registers import comparator_pkg::*; #(
	parameter int ram_addr_width = 4,
	parameter int fifo_depth_log2 = 2
) (
	input  logic clk,
	input  logic reset,
	input  addr_t fprint_address,
	input  logic fprint_write,
	input  data_t fprint_writedata,
	output logic fprint_waitrequest,
	output phys_core_t physical_core_id,
	output task_id_t fprint_task_id,
	output logic map_write,
	output logic map_logical,
	input  logic logical_core_id,
	input  logic [ram_addr_width-1:0] fprint_head_pointer,
	output logic increment_head_pointer,
	input  logic increment_hp_ack,
	output task_mask_t checkin_reg_out,
	input  logic [ram_addr_width-1:0] tail_pointer0,
	input  logic [ram_addr_width-1:0] tail_pointer1,
	output fprint_t fprint0,
	output fprint_t fprint1,
	input  logic task_verified,
	input  task_id_t verified_task,
	output logic fprint_reg_ack
);

	localparam int fifo_width = $bits(addr_t) + $bits(data_t);
	localparam int ram_depth = 1 << ram_addr_width;

	typedef enum logic {cap_idle, cap_ack} cap_state_t;
	typedef enum logic [2:0] {
		st_idle, st_read, st_decode, st_store,
		st_fp_check, st_fp_store, st_inc_head, st_verified
	} state_t;

	cap_state_t cap_state;
	state_t state;

	addr_t address_reg;
	data_t writedata_reg;
	logic [fifo_width-1:0] fifo_data_out;
	logic fifo_rd_en;
	logic fifo_empty;
	logic fifo_full;
	addr_t fifo_address;
	data_t fifo_writedata;

	logic cs_sel;
	logic fprint_sel;
	logic map_sel;
	logic fprint_block;

	task_mask_t checkout_reg [2];
	task_mask_t checkin_reg [2];
	// indexed by logical core, then half, then slot
	fprint_half_t fprint_mem [2][2][ram_depth];

	assign fifo_address = fifo_data_out[fifo_width-1 -: $bits(addr_t)];
	assign fifo_writedata = fifo_data_out[$bits(data_t)-1:0];

	assign physical_core_id = fifo_address[7:4];
	assign fprint_task_id = fifo_writedata[3:0];
	assign cs_sel = (fifo_address[3:0] == off_cs);
	assign fprint_sel = (fifo_address[3:0] == off_fprint);
	assign map_sel = (fifo_address[3:0] == off_map);
	assign fprint_block = fifo_writedata[block_bit];

	// bus capture, one write accepted per two cycles
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			cap_state <= cap_idle;
		else if (cap_state == cap_idle && fprint_write && !fifo_full)
			cap_state <= cap_ack;
		else
			cap_state <= cap_idle;
	end

	always_ff @(posedge clk) begin
		if (cap_state == cap_idle && fprint_write) begin
			address_reg <= fprint_address;
			writedata_reg <= fprint_writedata;
		end
	end

	assign fprint_waitrequest = (cap_state != cap_ack);

	write_fifo #(
		.fifo_depth_log2(fifo_depth_log2)
	) write_fifo_i (
		.clk(clk),
		.reset(reset),
		.data_in({address_reg, writedata_reg}),
		.wr_en(cap_state == cap_ack),
		.rd_en(fifo_rd_en),
		.data_out(fifo_data_out),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				// a finished task is cleared before more bus traffic is taken
				st_idle:
					if (task_verified)
						state <= st_verified;
					else if (!fifo_empty)
						state <= st_read;
				st_read:
					state <= st_decode;
				st_decode:
					state <= fprint_sel ? st_fp_check : st_store;
				st_fp_check:
					if (checkout_reg[logical_core_id][fprint_task_id])
						state <= st_fp_store;
					else
						state <= st_idle;
				st_fp_store:
					state <= fprint_block ? st_inc_head : st_idle;
				st_inc_head:
					if (increment_hp_ack)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign fifo_rd_en = (state == st_read);
	assign increment_head_pointer = (state == st_inc_head);
	assign fprint_reg_ack = (state == st_verified);
	assign map_write = (state == st_store) && map_sel;
	assign map_logical = fifo_writedata[0];
	assign checkin_reg_out = checkin_reg[0] & checkin_reg[1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			checkout_reg <= '{default: '0};
			checkin_reg <= '{default: '0};
		end else if (state == st_verified) begin
			for (int c = 0; c < 2; c++) begin
				checkout_reg[c][verified_task] <= 1'b0;
				checkin_reg[c][verified_task] <= 1'b0;
			end
		end else if (state == st_store && cs_sel) begin
			if (fifo_writedata[cs_dir_bit])
				checkout_reg[logical_core_id][fprint_task_id] <= 1'b1;
			// a checkin without a checkout is dropped
			else if (checkout_reg[logical_core_id][fprint_task_id])
				checkin_reg[logical_core_id][fprint_task_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		fprint0 <= {fprint_mem[0][1][tail_pointer0], fprint_mem[0][0][tail_pointer0]};
		fprint1 <= {fprint_mem[1][1][tail_pointer1], fprint_mem[1][0][tail_pointer1]};
		if (state == st_fp_store)
			fprint_mem[logical_core_id][fprint_block][fprint_head_pointer] <=
				fifo_writedata[31:16];
	end

endmodule

/* source/fprint_compare.sv */
`timescale 1ns/1ps

module fprint_compare import comparator_pkg::*; #(
	parameter int ram_addr_width = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic logical_core_id,
	input  logic increment_head_pointer,
	output logic increment_hp_ack,
	output logic [ram_addr_width-1:0] fprint_head_pointer,
	output logic [ram_addr_width-1:0] tail_pointer0,
	output logic [ram_addr_width-1:0] tail_pointer1,
	input  fprint_t fprint0,
	input  fprint_t fprint1,
	input  task_mask_t checkin_reg_out,
	output logic task_verified,
	output task_id_t verified_task,
	input  logic fprint_reg_ack,
	output logic result_valid,
	output logic result_ok,
	output task_id_t result_task
);

	typedef enum logic [1:0] {st_idle, st_wait, st_result, st_verify} state_t;

	state_t state;
	logic [ram_addr_width-1:0] head [2];
	logic [ram_addr_width-1:0] tail [2];
	logic fail_flag;
	logic pairs_pending;
	logic result_ready;
	task_id_t res_task;
	logic res_ok;

	function automatic task_id_t lowest_task(input task_mask_t mask);
		task_id_t id;
		id = '0;
		for (int i = $bits(task_mask_t) - 1; i >= 0; i--) begin
			if (mask[i])
				id = task_id_t'(i);
		end
		return id;
	endfunction

	assign fprint_head_pointer = head[logical_core_id];
	assign tail_pointer0 = tail[0];
	assign tail_pointer1 = tail[1];

	// a pair exists only when both cores have an unread entry
	assign pairs_pending = (head[0] != tail[0]) && (head[1] != tail[1]);
	assign result_ready = (checkin_reg_out != '0) && !pairs_pending;

	// head moves in the request cycle, so the request is a single pulse
	assign increment_hp_ack = increment_head_pointer;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			head <= '{default: '0};
		else if (increment_head_pointer)
			head[logical_core_id] <= head[logical_core_id] + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			tail <= '{default: '0};
			fail_flag <= 1'b0;
			res_task <= '0;
			res_ok <= 1'b0;
		end else begin
			case (state)
				st_idle:
					if (pairs_pending) begin
						state <= st_wait;
					end else if (result_ready) begin
						res_task <= lowest_task(checkin_reg_out);
						// leftover entries on either side mean unequal counts
						res_ok <= !fail_flag && (head[0] == tail[0]) && (head[1] == tail[1]);
						fail_flag <= 1'b0;
						// drop leftovers so the next task starts aligned
						tail[0] <= head[0];
						tail[1] <= head[1];
						state <= st_result;
					end
				// memory output at the tails is valid here
				st_wait: begin
					if (fprint0 != fprint1)
						fail_flag <= 1'b1;
					tail[0] <= tail[0] + 1'b1;
					tail[1] <= tail[1] + 1'b1;
					state <= st_idle;
				end
				st_result:
					state <= st_verify;
				st_verify:
					if (fprint_reg_ack)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign result_valid = (state == st_result);
	assign result_task = res_task;
	assign result_ok = res_ok;
	assign task_verified = (state == st_verify);
	assign verified_task = res_task;

endmodule

/* source/fprint_comparator_top.sv */
`timescale 1ns/1ps

module fprint_comparator_top import comparator_pkg::*; #(
	parameter int ram_addr_width = 4,
	parameter int fifo_depth_log2 = 2
) (
	input  logic clk,
	input  logic reset,
	input  addr_t address,
	input  logic write,
	input  data_t writedata,
	output logic waitrequest,
	output logic result_valid,
	output task_id_t result_task,
	output logic result_ok
);

	phys_core_t physical_core_id;
	logic logical_core_id;
	logic map_write;
	logic map_logical;
	logic [ram_addr_width-1:0] fprint_head_pointer;
	logic [ram_addr_width-1:0] tail_pointer0;
	logic [ram_addr_width-1:0] tail_pointer1;
	logic increment_head_pointer;
	logic increment_hp_ack;
	task_mask_t checkin_reg_out;
	fprint_t fprint0;
	fprint_t fprint1;
	logic task_verified;
	task_id_t verified_task;
	logic fprint_reg_ack;

	fprint_registers #(
		.ram_addr_width(ram_addr_width),
		.fifo_depth_log2(fifo_depth_log2)
	) fprint_registers_i (
		.clk(clk),
		.reset(reset),
		.fprint_address(address),
		.fprint_write(write),
		.fprint_writedata(writedata),
		.fprint_waitrequest(waitrequest),
		.physical_core_id(physical_core_id),
		.fprint_task_id(),
		.map_write(map_write),
		.map_logical(map_logical),
		.logical_core_id(logical_core_id),
		.fprint_head_pointer(fprint_head_pointer),
		.increment_head_pointer(increment_head_pointer),
		.increment_hp_ack(increment_hp_ack),
		.checkin_reg_out(checkin_reg_out),
		.tail_pointer0(tail_pointer0),
		.tail_pointer1(tail_pointer1),
		.fprint0(fprint0),
		.fprint1(fprint1),
		.task_verified(task_verified),
		.verified_task(verified_task),
		.fprint_reg_ack(fprint_reg_ack)
	);

	// map writes target the core that sent them
	core_id_map core_id_map_i (
		.clk(clk),
		.reset(reset),
		.map_write(map_write),
		.map_core(physical_core_id),
		.map_logical(map_logical),
		.physical_core_id(physical_core_id),
		.logical_core_id(logical_core_id)
	);

	fprint_compare #(
		.ram_addr_width(ram_addr_width)
	) fprint_compare_i (
		.clk(clk),
		.reset(reset),
		.logical_core_id(logical_core_id),
		.increment_head_pointer(increment_head_pointer),
		.increment_hp_ack(increment_hp_ack),
		.fprint_head_pointer(fprint_head_pointer),
		.tail_pointer0(tail_pointer0),
		.tail_pointer1(tail_pointer1),
		.fprint0(fprint0),
		.fprint1(fprint1),
		.checkin_reg_out(checkin_reg_out),
		.task_verified(task_verified),
		.verified_task(verified_task),
		.fprint_reg_ack(fprint_reg_ack),
		.result_valid(result_valid),
		.result_ok(result_ok),
		.result_task(result_task)
	);

endmodule

/* tb/tb_vectors.svh */
`ifndef tb_vectors_svh
`define tb_vectors_svh

// each entry holds the address, the write data, a flag to draw a new fingerprint,
// the flip mask for the half, a result flag, the expected task and the expected ok
typedef struct packed {
	logic [7:0] addr;
	logic [31:0] data;
	logic next_val;
	logic [15:0] flip;
	logic has_result;
	logic [3:0] exp_task;
	logic exp_ok;
} bus_vec_t;

localparam int num_vecs = 62;

bus_vec_t vecs [num_vecs] = '{
	// task 3 with three matching fingerprints sent back to back
	'{8'h00, 32'h13, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h13, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h03, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h03, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h03, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h03, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h03, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h03, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h23, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h03, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h03, 1'b0, 16'h0, 1'b1, 4'h3, 1'b1},
	// task 7 where the high half from core 1 differs
	'{8'h00, 32'h17, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h17, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h07, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h27, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h07, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h27, 1'b0, 16'h0100, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h07, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h07, 1'b0, 16'h0, 1'b1, 4'h7, 1'b0},
	// task 5 where core 0 sends one fingerprint more
	'{8'h00, 32'h15, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h15, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h05, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h25, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h05, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h25, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h05, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h25, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h05, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h05, 1'b0, 16'h0, 1'b1, 4'h5, 1'b0},
	// task 9 is never checked out so its mismatching values are dropped
	'{8'h01, 32'h09, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h29, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h09, 1'b0, 16'h0001, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h29, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h09, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h09, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h12, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h12, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h02, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h01, 32'h22, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h02, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h11, 32'h22, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h02, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h10, 32'h02, 1'b0, 16'h0, 1'b1, 4'h2, 1'b1},
	// physical 4 becomes logical 1 and physical 5 logical 0 before task 6 runs on them
	'{8'h42, 32'h01, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h52, 32'h00, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h40, 32'h16, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h50, 32'h16, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h41, 32'h06, 1'b1, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h41, 32'h26, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h51, 32'h06, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h51, 32'h26, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h40, 32'h06, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h50, 32'h06, 1'b0, 16'h0, 1'b1, 4'h6, 1'b1},
	// task 6 again with physical 4 against physical 0, a pair only after the remap
	'{8'h40, 32'h16, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h16, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h40, 32'h06, 1'b0, 16'h0, 1'b0, 4'h0, 1'b0},
	'{8'h00, 32'h06, 1'b0, 16'h0, 1'b1, 4'h6, 1'b1}
};

`endif

/* tb/tb_fprint_comparator.sv */
`timescale 1ns/1ps

module tb_fprint_comparator import comparator_pkg::*; ();

	logic clk;
	logic reset;
	addr_t address;
	logic write;
	data_t writedata;
	logic waitrequest;
	logic result_valid;
	task_id_t result_task;
	logic result_ok;

	int errors;
	int checks;
	int pulses;
	int expected_pulses;
	logic [31:0] rnd;

	`include "tb_vectors.svh"

	fprint_comparator_top #(
		.ram_addr_width(4),
		.fifo_depth_log2(2)
	) fprint_comparator_top_i (
		.clk(clk),
		.reset(reset),
		.address(address),
		.write(write),
		.writedata(writedata),
		.waitrequest(waitrequest),
		.result_valid(result_valid),
		.result_task(result_task),
		.result_ok(result_ok)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// holds the write until waitrequest is seen low before a rising edge
	task automatic bus_write(input addr_t a, input data_t d);
		address = a;
		writedata = d;
		write = 1'b1;
		@(negedge clk);
		while (waitrequest)
			@(negedge clk);
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic check_result(input task_id_t exp_task, input logic exp_ok);
		@(negedge clk);
		while (!result_valid)
			@(negedge clk);
		checks = checks + 1;
		if (result_task !== exp_task) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: result_task %0d, expected %0d",
				$time, result_task, exp_task);
		end
		if (result_ok !== exp_ok) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: task %0d result_ok %0b, expected %0b",
				$time, exp_task, result_ok, exp_ok);
		end
		@(posedge clk);
		#1;
	endtask

	// every result pulse is counted, also those nobody waits for
	always @(negedge clk) begin
		if (result_valid)
			pulses = pulses + 1;
	end

	initial begin
		repeat (num_vecs * 200) @(posedge clk);
		$display("timeout: the DUT stopped answering bus writes or results");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		bus_vec_t v;
		data_t wdata;
		fprint_half_t half;
		reset = 1'b1;
		write = 1'b0;
		address = '0;
		writedata = '0;
		errors = 0;
		checks = 0;
		pulses = 0;
		expected_pulses = 0;
		rnd = 32'd19726;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		for (int i = 0; i < num_vecs; i++) begin
			v = vecs[i];
			wdata = v.data;
			if (v.next_val)
				rnd = xorshift(rnd);
			// fingerprint halves are filled in from the current random value
			if (v.addr[3:0] == off_fprint) begin
				half = wdata[block_bit] ? rnd[31:16] : rnd[15:0];
				wdata[31:16] = half ^ v.flip;
			end
			bus_write(v.addr, wdata);
			if (v.has_result) begin
				expected_pulses = expected_pulses + 1;
				check_result(v.exp_task, v.exp_ok);
			end
		end
		// quiet period to catch a late extra result
		repeat (40) @(negedge clk);
		checks = checks + 1;
		if (pulses != expected_pulses) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: %0d result pulses, expected %0d",
				$time, pulses, expected_pulses);
		end
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+tb
source/comparator_pkg.sv
source/write_fifo.sv
source/core_id_map.sv
source/fprint_registers.sv
source/fprint_compare.sv
source/fprint_comparator_top.sv
tb/tb_fprint_comparator.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_fprint_comparator -f compile.f -Mdir obj_dir
	./obj_dir/Vtb_fprint_comparator | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
